// File: tb/aib_tx_input.txt
# Transmit channel stimulus, one operation per line, values in hex
# CFG addr data | WORD word78 drop(0/1) | LPBK din rx_reg_dout rx_fifo_data_out
# FIFO 1:1 at read delays 0, 3 and 7
WORD 0123456789abcdef0123 0
WORD 3fedcba9876543210fed 0
CFG 1 03
WORD 2aaaa5555aaaa5555aaa 0
CFG 1 07
WORD 1c3a5f7e9d0b2468ace1 0
# FIFO 2:1, plain then swapped
CFG 0 01
WORD 3ffff000000fffff0001 0
WORD 0deadbeefcafef00d123 0
CFG 0 11
WORD 2468ace13579bdf02468 0
# Read hold, the last two pushes find the FIFO full
CFG 0 20
WORD 01000000000000000001 0
WORD 02000000000000000002 0
WORD 03000000000000000003 0
WORD 04000000000000000004 0
WORD 05000000000000000005 0
WORD 06000000000000000006 0
WORD 07000000000000000007 0
WORD 08000000000000000008 0
WORD 09000000000000000009 1
WORD 0a00000000000000000a 1
CFG 0 00
# Register mode, then loopback 3 through the register path
CFG 0 03
WORD 15555555555aa55aa55a 0
LPBK 0000000000 a5a5a5a5a5 00000000000000000000
CFG 0 0b
WORD 0000000000000000beef 0
# Loopback 2 straight from din
CFG 0 04
LPBK 123456789a 0000000000 00000000000000000000
LPBK fedcba9876 0000000000 00000000000000000000
# Loopback 3 into the FIFO, 1:1 then 2:1
CFG 0 0c
LPBK 0000000000 0000000000 f0123456789abcdef012
WORD 00000000000000000000 0
CFG 0 0d
LPBK 0000000000 0000000000 c3c3c3c3c3c3c3c3c3c3
WORD 00000000000000000000 0
CFG 0 00

// File: project.f
+incdir+logic
logic/aib_tx_pkg.sv
logic/aib_tx_csr.sv
logic/aib_tx_fifo.sv
logic/aib_tx_gearbox.sv
logic/aib_tx_chnl.sv
tb/aib_tx_chnl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the transmit channel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module aib_tx_chnl_tb -o aib_tx_sim
out=$(./obj_dir/aib_tx_sim)
echo "$out"
if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1

// File: tb/aib_tx_chnl_tb.sv
/* Self-checking testbench for the AIB transmit channel. Replays tb/aib_tx_input.txt,
   then random bursts, and checks every beat on dout against a model of the beat rules. */
`default_nettype none

module aib_tx_chnl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import aib_tx_pkg::*;

  logic        m_ns_fwd_clk;
  logic        rst_n;
  logic        cfg_wr;
  logic        cfg_addr;
  logic [7:0]  cfg_wdata;
  tx_word_t    data_in;
  logic        data_valid;
  logic [39:0] din;
  logic [39:0] rx_reg_dout;
  logic [79:0] rx_fifo_data_out;
  tx_beat_t    dout;
  logic        dout_valid;
  logic        fifo_empty;
  logic        fifo_full;

  tx_beat_t    exp_q[$];    // Beats still owed by the DUT
  int          errors;
  int          timeouts;
  logic [1:0]  m_mode;      // Model copy of the mode register
  logic [1:0]  m_lpbk;
  logic        m_swap;
  logic        m_hold;
  logic [63:0] rand_state;

  aib_tx_chnl i_aib_tx_chnl (.*);

  initial begin
    m_ns_fwd_clk = 1'b0;
    forever #20 m_ns_fwd_clk = ~m_ns_fwd_clk;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    return y ^ (y << 17);
  endfunction

  function automatic tx_word_t random_word();
    logic [63:0] hi;
    rand_state = xorshift(rand_state);
    hi = rand_state;
    rand_state = xorshift(rand_state);
    return {hi[13:0], rand_state};
  endfunction

  // Strobes last one cycle only
  task automatic next_cycle();
    @(negedge m_ns_fwd_clk);
    cfg_wr     = 1'b0;
    data_valid = 1'b0;
  endtask

  // Beats that one accepted word must produce in the current mode
  task automatic expect_word(input tx_word_t word);
    tx_word_t src;
    src = (m_lpbk == LPBK_3_FIFO) ? tx_word_t'(rx_fifo_data_out[77:0]) : word;
    if (m_lpbk != LPBK_2) begin
      if (m_mode == REG_MODE) begin
        exp_q.push_back((m_lpbk == LPBK_3_REG) ? rx_reg_dout : word[39:0]);
      end else if (m_mode == FIFO_2TO1) begin
        exp_q.push_back(m_swap ? {1'b0, src[77:39]} : {1'b0, src[38:0]});
        exp_q.push_back(m_swap ? {1'b0, src[38:0]} : {1'b0, src[77:39]});
      end else begin
        exp_q.push_back(src[39:0]);  // 1:1 and the reserved code
      end
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || fifo_empty !== 1'b1) && cycles < 200) begin
      next_cycle();
      cycles++;
    end
    if (exp_q.size() != 0 || fifo_empty !== 1'b1) begin
      timeouts++;
      $display("Timeout at %0t: %0d beats never came out or the FIFO did not empty",
               $time, exp_q.size());
      exp_q.delete();
    end
    repeat (3) next_cycle();  // Let hidden gearbox beats settle
  endtask

  task automatic cfg_write(input logic addr, input logic [7:0] data);
    if (!m_hold) begin
      drain();
    end
    next_cycle();
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    if (!addr) begin
      m_mode = data[1:0];
      m_lpbk = data[3:2];
      m_swap = data[4];
      m_hold = data[5];
    end
  endtask

  task automatic push_word(input tx_word_t word, input logic drop);
    next_cycle();
    assert (fifo_full === drop) else begin
      errors++;
      $display("CHECK FAILED at %0t: fifo_full %b at push, expected %b", $time, fifo_full, drop);
    end
    data_in    = word;
    data_valid = 1'b1;
    if (!drop) begin
      expect_word(word);
    end
  endtask

  task automatic set_loopback(input logic [39:0] d, input logic [39:0] r, input logic [79:0] f);
    next_cycle();
    din              = d;
    rx_reg_dout      = r;
    rx_fifo_data_out = f;
    if (m_lpbk == LPBK_2) begin
      #1;
      assert (dout === d && dout_valid === 1'b0) else begin
        errors++;
        $display("CHECK FAILED at %0t: loopback 2 dout %h valid %b, expected %h valid 0",
                 $time, dout, dout_valid, d);
      end
    end
  endtask

  // Each valid beat against the oldest expected one
  always @(negedge m_ns_fwd_clk) begin
    tx_beat_t exp_beat;
    if (rst_n === 1'b1 && dout_valid === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("CHECK FAILED at %0t: unexpected beat %h", $time, dout);
      end
      if (exp_q.size() != 0) begin
        exp_beat = exp_q.pop_front();
        assert (dout === exp_beat) else begin
          errors++;
          $display("CHECK FAILED at %0t: dout %h, expected %h", $time, dout, exp_beat);
        end
      end
    end
  end

  initial begin
    int              fd;
    int              n;
    logic [63:0]     kind;
    logic [7:0]      addr_val;
    logic [7:0]      data_val;
    tx_word_t        word_val;
    int              drop_val;
    logic [39:0]     din_val;
    logic [39:0]     reg_val;
    logic [79:0]     fifo_val;
    logic [8*128-1:0] skip;
    rst_n            = 1'b0;
    cfg_wr           = 1'b0;
    cfg_addr         = 1'b0;
    cfg_wdata        = '0;
    data_in          = '0;
    data_valid       = 1'b0;
    din              = '0;
    rx_reg_dout      = '0;
    rx_fifo_data_out = '0;
    errors           = 0;
    timeouts         = 0;
    m_mode           = 2'b00;
    m_lpbk           = 2'b00;
    m_swap           = 1'b0;
    m_hold           = 1'b0;
    rand_state       = 64'd62895;
    repeat (4) @(posedge m_ns_fwd_clk);
    next_cycle();
    rst_n = 1'b1;
    next_cycle();
    assert (fifo_empty === 1'b1 && fifo_full === 1'b0 && dout_valid === 1'b0) else begin
      errors++;
      $display("CHECK FAILED at %0t: flags after reset empty %b full %b valid %b",
               $time, fifo_empty, fifo_full, dout_valid);
    end
    fd = $fopen("tb/aib_tx_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file tb/aib_tx_input.txt");
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "CFG") begin
          n = $fscanf(fd, "%h %h", addr_val, data_val);
          cfg_write(addr_val[0], data_val);
        end else if (kind == "WORD") begin
          n = $fscanf(fd, "%h %d", word_val, drop_val);
          push_word(word_val, drop_val[0]);
        end else if (kind == "LPBK") begin
          n = $fscanf(fd, "%h %h %h", din_val, reg_val, fifo_val);
          set_loopback(din_val, reg_val, fifo_val);
        end else begin
          n = $fgets(skip, fd);  // Comment line
        end
      end
      $fclose(fd);
    end
    // Random bursts, 1:1 at every read delay, then 2:1 plain and swapped
    cfg_write(1'b0, 8'h00);
    for (int d = 0; d < 8; d++) begin
      cfg_write(1'b1, 8'(d));
      repeat (6) push_word(random_word(), 1'b0);
    end
    cfg_write(1'b0, 8'h01);
    repeat (6) push_word(random_word(), 1'b0);
    cfg_write(1'b0, 8'h11);
    repeat (6) push_word(random_word(), 1'b0);
    drain();
    $display("Result: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/aib_tx_chnl.sv
/* Top of the AIB adapter transmit channel. Chooses loopback sources, runs the FIFO and
   gearbox or the single register stage, and muxes the selected path onto dout. */
`default_nettype none

module aib_tx_chnl (
  input  logic                  m_ns_fwd_clk,
  input  logic                  rst_n,
  input  logic                  cfg_wr,
  input  logic                  cfg_addr,
  input  logic [7:0]            cfg_wdata,
  input  aib_tx_pkg::tx_word_t  data_in,
  input  logic                  data_valid,
  input  logic [39:0]           din,               // rx io bus, loopback 2
  input  logic [39:0]           rx_reg_dout,       // rx reg data, loopback 3 reg
  input  logic [79:0]           rx_fifo_data_out,  // rx FIFO data, loopback 3 fifo
  output aib_tx_pkg::tx_beat_t  dout,
  output logic                  dout_valid,
  output logic                  fifo_empty,
  output logic                  fifo_full
);

  import aib_tx_pkg::*;

  tx_cfg_t  cfg;
  logic     loopback2;
  logic     loopback3_reg;
  logic     loopback3_fifo;
  tx_word_t fifo_wdata;
  tx_beat_t reg_din;
  tx_beat_t reg_dout;
  logic     reg_valid;
  logic     rd_valid;
  logic     rd_ready;
  tx_word_t rd_data;
  tx_beat_t fifo_beat;
  logic     fifo_beat_valid;

  assign loopback2      = (cfg.lpbk_mode == LPBK_2);
  assign loopback3_reg  = (cfg.lpbk_mode == LPBK_3_REG);
  assign loopback3_fifo = (cfg.lpbk_mode == LPBK_3_FIFO);

  assign fifo_wdata = loopback3_fifo ? tx_word_t'(rx_fifo_data_out[77:0]) : data_in;
  assign reg_din    = loopback3_reg ? rx_reg_dout : data_in[39:0];

  // Register mode stage
  always_ff @(posedge m_ns_fwd_clk) begin
    if (!rst_n) begin
      reg_valid <= 1'b0;
    end else begin
      reg_valid <= data_valid;
    end
  end

  always_ff @(posedge m_ns_fwd_clk) begin
    reg_dout <= reg_din;
  end

  aib_tx_csr i_aib_tx_csr (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg          (cfg)
  );

  aib_tx_fifo i_aib_tx_fifo (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .rst_n        (rst_n),
    .wr_en        (data_valid),
    .wr_data      (fifo_wdata),
    .rd_ready     (rd_ready),
    .rd_delay     (cfg.rd_delay),
    .rd_hold      (cfg.rd_hold),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .fifo_empty   (fifo_empty),
    .fifo_full    (fifo_full)
  );

  aib_tx_gearbox i_aib_tx_gearbox (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .rst_n        (rst_n),
    .fifo_mode    (cfg.fifo_mode),
    .swap_en      (cfg.swap_en),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .rd_ready     (rd_ready),
    .beat         (fifo_beat),
    .beat_valid   (fifo_beat_valid)
  );

  // Output select, loopback 2 bypasses everything
  always_comb begin
    if (loopback2) begin
      dout       = din;
      dout_valid = 1'b0;
    end else if (cfg.fifo_mode == REG_MODE) begin
      dout       = reg_dout;
      dout_valid = reg_valid;
    end else begin
      dout       = fifo_beat;
      dout_valid = fifo_beat_valid;
    end
  end

endmodule

`default_nettype wire

// File: logic/aib_tx_gearbox.sv
/* Splits FIFO words into output beats: one beat per word in 1:1 mode, two in 2:1 mode.
   Beats are registered and leave one cycle after the word is taken. */
`default_nettype none

`include "aib_tx_cfg.svh"

module aib_tx_gearbox (
  input  logic                       m_ns_fwd_clk,
  input  logic                       rst_n,
  input  aib_tx_pkg::tx_fifo_mode_e  fifo_mode,
  input  logic                       swap_en,
  input  logic                       rd_valid,
  input  aib_tx_pkg::tx_word_t       rd_data,
  output logic                       rd_ready,
  output aib_tx_pkg::tx_beat_t       beat,
  output logic                       beat_valid
);

  import aib_tx_pkg::*;

  localparam int HALF_W = `AIB_TX_WORD_W / 2;
  localparam int PAD_W  = `AIB_TX_BEAT_W - HALF_W;

  logic              take;
  logic              phase;       // Second beat of a 2:1 word pending
  logic [HALF_W-1:0] lo_half;
  logic [HALF_W-1:0] hi_half;
  logic [HALF_W-1:0] second_half;

  assign lo_half = rd_data[HALF_W-1:0];
  assign hi_half = rd_data[`AIB_TX_WORD_W-1:HALF_W];

  // Busy only while the held half goes out
  assign rd_ready = !phase;
  assign take     = rd_valid && rd_ready;

  always_ff @(posedge m_ns_fwd_clk) begin
    if (!rst_n) begin
      phase      <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= take || phase;
      phase      <= take && (fifo_mode == FIFO_2TO1);
    end
  end

  // Payload path
  always_ff @(posedge m_ns_fwd_clk) begin
    if (phase) begin
      beat <= {{PAD_W{1'b0}}, second_half};
    end else if (take) begin
      if (fifo_mode == FIFO_2TO1) begin
        beat        <= {{PAD_W{1'b0}}, (swap_en ? hi_half : lo_half)};
        second_half <= swap_en ? lo_half : hi_half;
      end else begin
        beat <= rd_data[`AIB_TX_BEAT_W-1:0];  // Low bits only in 1:1
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/aib_tx_fifo.sv
/* Phase-compensation FIFO of the transmit channel. Words are shown first-word-fall-through
   once the read side is armed, rd_delay+1 cycles after the FIFO first holds data. */
`default_nettype none

`include "aib_tx_cfg.svh"

module aib_tx_fifo (
  input  logic                  m_ns_fwd_clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  aib_tx_pkg::tx_word_t  wr_data,
  input  logic                  rd_ready,
  input  logic [2:0]            rd_delay,
  input  logic                  rd_hold,
  output logic                  rd_valid,
  output aib_tx_pkg::tx_word_t  rd_data,
  output logic                  fifo_empty,
  output logic                  fifo_full
);

  import aib_tx_pkg::*;

  localparam int DEPTH = `AIB_TX_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  tx_word_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             armed;     // Read side released
  logic [2:0]       wait_cnt;  // Counts up to rd_delay

  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == CNT_W'(DEPTH));

  assign push     = wr_en && !fifo_full;  // Write while full is lost
  assign rd_valid = armed && !fifo_empty && !rd_hold;
  assign pop      = rd_valid && rd_ready;
  assign rd_data  = mem[rd_ptr];          // Head of queue, no read latency

  always_ff @(posedge m_ns_fwd_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge m_ns_fwd_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Phase compensation: hold the read side off until the write side has a head start
  always_ff @(posedge m_ns_fwd_clk) begin
    if (!rst_n) begin
      armed    <= 1'b0;
      wait_cnt <= '0;
    end else if (!armed) begin
      if (fifo_empty) begin
        wait_cnt <= '0;
      end else if (wait_cnt == rd_delay) begin
        armed    <= 1'b1;
        wait_cnt <= '0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else if (fifo_empty) begin
      armed <= 1'b0;  // Drained, restart the wait on next fill
    end
  end

endmodule

`default_nettype wire

// File: logic/aib_tx_csr.sv
/* Configuration registers for the transmit channel, written through a one-cycle
   strobe port. Address 0 carries the mode bits, address 1 the read delay. */
`default_nettype none

module aib_tx_csr (
  input  logic                 m_ns_fwd_clk,
  input  logic                 rst_n,
  input  logic                 cfg_wr,
  input  logic                 cfg_addr,
  input  logic [7:0]           cfg_wdata,
  output aib_tx_pkg::tx_cfg_t  cfg
);

  import aib_tx_pkg::*;

  localparam logic ADDR_MODE  = 1'b0;
  localparam logic ADDR_DELAY = 1'b1;

  // Reserved code 2'b10 falls back to plain 1:1 FIFO mode
  function automatic tx_fifo_mode_e decode_fifo_mode(input logic [1:0] code);
    tx_fifo_mode_e mode;
    case (code)
      2'b01:   mode = FIFO_2TO1;
      2'b11:   mode = REG_MODE;
      default: mode = FIFO_1TO1;
    endcase
    return mode;
  endfunction

  logic wr_mode;
  logic wr_delay;

  assign wr_mode  = cfg_wr && (cfg_addr == ADDR_MODE);
  assign wr_delay = cfg_wr && (cfg_addr == ADDR_DELAY);

  always_ff @(posedge m_ns_fwd_clk) begin
    if (!rst_n) begin
      cfg <= '0;
    end else begin
      if (wr_mode) begin
        cfg.fifo_mode <= decode_fifo_mode(cfg_wdata[1:0]);
        cfg.lpbk_mode <= tx_lpbk_mode_e'(cfg_wdata[3:2]);
        cfg.swap_en   <= cfg_wdata[4];
        cfg.rd_hold   <= cfg_wdata[5];
      end
      if (wr_delay) begin
        cfg.rd_delay <= cfg_wdata[2:0];  // Upper bits ignored
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/aib_tx_pkg.sv
/* Shared types for the AIB transmit channel: mode encodings, word and beat types,
   and the configuration struct driven by the register block. */
`default_nettype none

`include "aib_tx_cfg.svh"

package aib_tx_pkg;

  // Transmit path selection, 2'b10 is reserved
  typedef enum logic [1:0] {
    FIFO_1TO1 = 2'b00,
    FIFO_2TO1 = 2'b01,
    REG_MODE  = 2'b11
  } tx_fifo_mode_e;

  // Loopback selection
  typedef enum logic [1:0] {
    LPBK_NONE   = 2'b00,
    LPBK_2      = 2'b01,  // rx io bus straight to dout
    LPBK_3_REG  = 2'b10,  // rx register data into reg path
    LPBK_3_FIFO = 2'b11   // rx FIFO data into tx FIFO
  } tx_lpbk_mode_e;

  typedef logic [`AIB_TX_WORD_W-1:0] tx_word_t;
  typedef logic [`AIB_TX_BEAT_W-1:0] tx_beat_t;

  typedef struct packed {
    tx_fifo_mode_e fifo_mode;
    tx_lpbk_mode_e lpbk_mode;
    logic          swap_en;   // 2:1 mode, upper half first
    logic          rd_hold;   // Stall the FIFO read side
    logic [2:0]    rd_delay;  // Extra wait after first fill
  } tx_cfg_t;

endpackage

`default_nettype wire

// File: logic/aib_tx_cfg.svh
/* Size constants for the AIB transmit channel.
   Included by the package and by any RTL block that sizes storage or slices words. */
`ifndef AIB_TX_CFG_SVH
`define AIB_TX_CFG_SVH

// Phase-compensation FIFO
`define AIB_TX_FIFO_DEPTH 8   // Entries, power of two

// Datapath widths
`define AIB_TX_WORD_W     78  // Transmit word from the adapter
`define AIB_TX_BEAT_W     40  // Beat toward the AIB io

// In 2:1 mode a word splits into two halves of WORD_W/2 bits,
// each zero-extended to a full beat

`endif
